//--- hw/i2c_slave_pkg.sv
/*
  i2c slave shared definitions
  protocol widths, the one-hot transfer states and the packed
  bundles passed between sampler, bit engine, FSM and register port
*/
package i2c_slave_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // protocol widths
  ////////////////////////////////////////////////////////////////////////////
  localparam int byte_w     = 8;
  localparam int addr_w     = 7;
  localparam int port_count = 16;

  // bit counter value during the ninth (ack) slot
  localparam logic [3:0] ack_bit_index = 4'd8;

  // one-hot transfer states
  typedef enum logic [4:0] {
    idle       = 5'b00001,
    address    = 5'b00010,
    location   = 5'b00100,
    write_data = 5'b01000,
    read_data  = 5'b10000
  } xfer_state_e;

  ////////////////////////////////////////////////////////////////////////////
  // bundles between blocks
  ////////////////////////////////////////////////////////////////////////////

  // single-cycle line events plus synchronized sda
  typedef struct packed {
    logic scl_rise;
    logic scl_fall;
    logic start;
    logic stop;
    logic sda_level;
  } bus_events_t;

  // bit engine results toward the FSM
  typedef struct packed {
    logic              byte_done;
    logic              slot_end;
    logic              ack_sample;
    logic [byte_w-1:0] rx_byte;
  } bit_status_t;

  // transfer control back to the bit engine
  typedef struct packed {
    xfer_state_e state;
    logic        rd_wr;
    logic        addr_ok;
    logic        master_nack;
  } slave_ctrl_t;

  // register side access, one-hot selects
  typedef struct packed {
    logic [port_count-1:0] port_sel;
    logic [port_count-1:0] offset_sel;
    logic [byte_w-1:0]     wdata;
    logic                  wr;
    logic                  rd;
  } reg_access_t;

  // register input ports
  typedef logic [port_count-1:0][byte_w-1:0] port_bytes_t;

endpackage

//--- hw/i2c_line_sampler.sv
/*
  i2c line sampler
  brings scl and sda into the sysclk domain and turns their
  transitions into single-cycle edge, start and stop events
*/
module i2c_line_sampler (
  input  logic                       sysclk,
  input  logic                       reset_n,
  input  logic                       scl,
  input  logic                       sda,
  output i2c_slave_pkg::bus_events_t events
);

  // [0] first stage, [1] second stage
  logic [1:0] scl_sync;
  logic [1:0] sda_sync;
  // previous synchronized values for edge detect
  logic       scl_prev;
  logic       sda_prev;

  logic       scl_rise_w;
  logic       scl_fall_w;
  logic       start_w;
  logic       stop_w;

  // bus idles high so everything resets to 1
  always_ff @(posedge sysclk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      scl_sync <= 2'b11;
      sda_sync <= 2'b11;
      scl_prev <= 1'b1;
      sda_prev <= 1'b1;
    end
    else
    begin
      scl_sync <= {scl_sync[0], scl};
      sda_sync <= {sda_sync[0], sda};
      scl_prev <= scl_sync[1];
      sda_prev <= sda_sync[1];
    end
  end

  assign scl_rise_w = scl_sync[1] & ~scl_prev;
  assign scl_fall_w = ~scl_sync[1] & scl_prev;
  // sda moving while scl high
  assign start_w    = scl_sync[1] & sda_prev & ~sda_sync[1];
  assign stop_w     = scl_sync[1] & ~sda_prev & sda_sync[1];

  // registered events, three sysclk after the pin
  always_ff @(posedge sysclk or negedge reset_n)
  begin
    if (!reset_n)
      events <= '{scl_rise: 1'b0, scl_fall: 1'b0, start: 1'b0, stop: 1'b0, sda_level: 1'b1};
    else
      events <= '{scl_rise: scl_rise_w, scl_fall: scl_fall_w, start: start_w,
                  stop: stop_w, sda_level: sda_sync[1]};
  end

endmodule

//--- hw/i2c_bit_engine.sv
/*
  i2c bit engine
  counts the nine scl slots of each byte, shifts received bits in,
  shifts read data out and drives the open-drain sda pull-down
*/
module i2c_bit_engine (
  input  logic                                  sysclk,
  input  logic                                  reset_n,
  input  i2c_slave_pkg::bus_events_t            events,
  input  i2c_slave_pkg::slave_ctrl_t            ctrl,
  input  logic [i2c_slave_pkg::byte_w-1:0]      read_byte,
  output i2c_slave_pkg::bit_status_t            status,
  output logic                                  sda_pull
);

  logic [3:0]                         bit_cnt;
  logic [i2c_slave_pkg::byte_w-1:0]   rx_shift;
  logic [i2c_slave_pkg::byte_w-1:0]   tx_shift;
  logic                               byte_done_q;
  logic                               slot_end_q;
  logic                               ack_sample_q;

  logic                               active;
  logic                               slot_end_w;
  logic                               tx_first_w;
  logic                               tx_next_w;
  logic                               ack_drive_w;

  assign active     = ctrl.state != i2c_slave_pkg::idle;
  // falling scl that closes the ack slot
  assign slot_end_w = events.scl_fall && (bit_cnt == i2c_slave_pkg::ack_bit_index + 4'd1);

  // a read byte starts after an acked read address or a master ack
  assign tx_first_w = (ctrl.state == i2c_slave_pkg::address && ctrl.addr_ok && ctrl.rd_wr)
                   || (ctrl.state == i2c_slave_pkg::read_data && !ctrl.master_nack);
  // bits 6..0 of a read byte
  assign tx_next_w  = ctrl.state == i2c_slave_pkg::read_data && !ctrl.master_nack
                   && bit_cnt != 4'd0 && bit_cnt < i2c_slave_pkg::ack_bit_index;
  // slave acks matched address and every write byte
  assign ack_drive_w = (ctrl.state == i2c_slave_pkg::address && ctrl.addr_ok)
                    || ctrl.state == i2c_slave_pkg::location
                    || ctrl.state == i2c_slave_pkg::write_data;

  ////////////////////////////////////////////////////////////////////////////
  // slot counter and status pulses
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge sysclk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      bit_cnt      <= 4'd0;
      byte_done_q  <= 1'b0;
      slot_end_q   <= 1'b0;
      ack_sample_q <= 1'b0;
    end
    else
    begin
      if (events.start || events.stop || slot_end_w)
        bit_cnt <= 4'd0;
      else if (events.scl_rise && active)
        bit_cnt <= bit_cnt + 4'd1;
      // eighth rise done
      byte_done_q  <= events.scl_rise && active
                   && (bit_cnt == i2c_slave_pkg::ack_bit_index - 4'd1);
      // ninth rise, ack bit on the line
      ack_sample_q <= events.scl_rise && active && (bit_cnt == i2c_slave_pkg::ack_bit_index);
      slot_end_q   <= slot_end_w;
    end
  end

  // receive shifter, ack bit kept out
  always_ff @(posedge sysclk)
  begin
    if (events.scl_rise && bit_cnt < i2c_slave_pkg::ack_bit_index)
      rx_shift <= {rx_shift[i2c_slave_pkg::byte_w-2:0], events.sda_level};
  end

  // transmit shifter, msb first
  always_ff @(posedge sysclk)
  begin
    if (events.scl_fall)
    begin
      if (slot_end_w && tx_first_w)
        tx_shift <= read_byte;
      else if (tx_next_w)
        tx_shift <= {tx_shift[i2c_slave_pkg::byte_w-2:0], 1'b0};
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // open-drain sda, changes only while scl is low
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge sysclk or negedge reset_n)
  begin
    if (!reset_n)
      sda_pull <= 1'b0;
    else if (events.start || events.stop || !active)
      sda_pull <= 1'b0;
    else if (events.scl_fall)
    begin
      if (bit_cnt == i2c_slave_pkg::ack_bit_index)
        sda_pull <= ack_drive_w;
      // first bit of the next read byte
      else if (slot_end_w)
        sda_pull <= tx_first_w & ~read_byte[i2c_slave_pkg::byte_w-1];
      else if (tx_next_w)
        sda_pull <= ~tx_shift[i2c_slave_pkg::byte_w-2];
      else
        sda_pull <= 1'b0;
    end
  end

  assign status = '{byte_done: byte_done_q, slot_end: slot_end_q,
                    ack_sample: ack_sample_q, rx_byte: rx_shift};

endmodule

//--- hw/i2c_transaction_fsm.sv
/*
  i2c transaction FSM
  follows a transfer from address through location and data bytes,
  checks the device address, keeps the location pointer and issues
  the register write and read strobes
*/
module i2c_transaction_fsm (
  input  logic                                  sysclk,
  input  logic                                  reset_n,
  input  i2c_slave_pkg::bus_events_t            events,
  input  i2c_slave_pkg::bit_status_t            status,
  input  logic [i2c_slave_pkg::addr_w-1:0]      device_address,
  output i2c_slave_pkg::slave_ctrl_t            ctrl,
  output logic [i2c_slave_pkg::byte_w-1:0]      location,
  output logic                                  wr_strobe,
  output logic                                  rd_strobe
);

  i2c_slave_pkg::xfer_state_e xfer_state;
  logic                       rd_wr;
  logic                       addr_ok;
  logic                       master_nack;

  ////////////////////////////////////////////////////////////////////////////
  // state register
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge sysclk or negedge reset_n)
  begin
    if (!reset_n)
      xfer_state <= i2c_slave_pkg::idle;
    // start from anywhere, repeated start included
    else if (events.start)
      xfer_state <= i2c_slave_pkg::address;
    else if (events.stop)
      xfer_state <= i2c_slave_pkg::idle;
    else if (status.slot_end)
    begin
      case (xfer_state)
        i2c_slave_pkg::address:
          xfer_state <= addr_ok ? (rd_wr ? i2c_slave_pkg::read_data : i2c_slave_pkg::location)
                                : i2c_slave_pkg::idle;
        i2c_slave_pkg::location:
          xfer_state <= i2c_slave_pkg::write_data;
        i2c_slave_pkg::write_data:
          xfer_state <= i2c_slave_pkg::write_data;
        // master nack ends the read
        i2c_slave_pkg::read_data:
          xfer_state <= master_nack ? i2c_slave_pkg::idle : i2c_slave_pkg::read_data;
        default:
          xfer_state <= i2c_slave_pkg::idle;
      endcase
    end
  end

  // address match and direction bit
  always_ff @(posedge sysclk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      addr_ok <= 1'b0;
      rd_wr   <= 1'b0;
    end
    else if (events.start || events.stop)
    begin
      addr_ok <= 1'b0;
      rd_wr   <= 1'b0;
    end
    else if (status.byte_done && xfer_state == i2c_slave_pkg::address)
    begin
      addr_ok <= status.rx_byte[i2c_slave_pkg::byte_w-1:1] == device_address;
      rd_wr   <= status.rx_byte[0];
    end
  end

  // ack slot of a read byte, sda high means nack
  always_ff @(posedge sysclk or negedge reset_n)
  begin
    if (!reset_n)
      master_nack <= 1'b0;
    else if (events.start || events.stop)
      master_nack <= 1'b0;
    else if (status.ack_sample && xfer_state == i2c_slave_pkg::read_data)
      master_nack <= events.sda_level;
  end

  ////////////////////////////////////////////////////////////////////////////
  // location pointer and read strobe
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge sysclk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      location  <= '0;
      rd_strobe <= 1'b0;
    end
    else
    begin
      rd_strobe <= 1'b0;
      // first write byte is the pointer
      if (status.byte_done && xfer_state == i2c_slave_pkg::location)
        location <= status.rx_byte;
      else if (status.ack_sample)
      begin
        if (xfer_state == i2c_slave_pkg::write_data)
          location <= location + 8'd1;
        // master acked, fetch the next location
        else if (xfer_state == i2c_slave_pkg::read_data && !events.sda_level)
        begin
          location  <= location + 8'd1;
          rd_strobe <= 1'b1;
        end
        // acked read address, fetch the current location
        else if (xfer_state == i2c_slave_pkg::address && addr_ok && rd_wr)
          rd_strobe <= 1'b1;
      end
    end
  end

  // write data byte complete
  assign wr_strobe = status.byte_done && (xfer_state == i2c_slave_pkg::write_data);

  assign ctrl = '{state: xfer_state, rd_wr: rd_wr, addr_ok: addr_ok, master_nack: master_nack};

endmodule

//--- hw/i2c_register_port.sv
/*
  i2c register port
  decodes the location pointer into one-hot port and offset selects,
  issues single-cycle register strobes and picks the read byte
*/
module i2c_register_port (
  input  logic                                  sysclk,
  input  logic                                  reset_n,
  input  logic [i2c_slave_pkg::byte_w-1:0]      location,
  input  logic                                  wr_strobe,
  input  logic                                  rd_strobe,
  input  logic [i2c_slave_pkg::byte_w-1:0]      wdata,
  input  i2c_slave_pkg::port_bytes_t            port_data,
  output i2c_slave_pkg::reg_access_t            reg_access,
  output logic [i2c_slave_pkg::byte_w-1:0]      read_byte
);

  logic [i2c_slave_pkg::port_count-1:0] port_dec;
  logic [i2c_slave_pkg::port_count-1:0] offset_dec;
  logic [i2c_slave_pkg::byte_w-1:0]     port_pick;

  logic [i2c_slave_pkg::port_count-1:0] port_sel_q;
  logic [i2c_slave_pkg::port_count-1:0] offset_sel_q;
  logic [i2c_slave_pkg::byte_w-1:0]     wdata_q;
  logic                                 wr_q;
  logic                                 rd_q;

  // upper nibble picks the port, lower nibble the offset
  always_comb
  begin
    port_dec                  = '0;
    offset_dec                = '0;
    port_dec[location[7:4]]   = 1'b1;
    offset_dec[location[3:0]] = 1'b1;
  end

  // and-or mux over the one-hot port select
  always_comb
  begin
    port_pick = '0;
    for (int i = 0; i < i2c_slave_pkg::port_count; i++)
    begin
      if (port_dec[i])
        port_pick = port_pick | port_data[i];
    end
  end

  // strobes and selects
  always_ff @(posedge sysclk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      wr_q         <= 1'b0;
      rd_q         <= 1'b0;
      port_sel_q   <= '0;
      offset_sel_q <= '0;
    end
    else
    begin
      wr_q <= wr_strobe;
      rd_q <= rd_strobe;
      if (wr_strobe || rd_strobe)
      begin
        port_sel_q   <= port_dec;
        offset_sel_q <= offset_dec;
      end
    end
  end

  // write data and read byte held until the next strobe
  always_ff @(posedge sysclk)
  begin
    if (wr_strobe)
      wdata_q <= wdata;
    if (rd_strobe)
      read_byte <= port_pick;
  end

  assign reg_access = '{port_sel: port_sel_q, offset_sel: offset_sel_q,
                        wdata: wdata_q, wr: wr_q, rd: rd_q};

endmodule

//--- hw/i2c_slave_top.sv
/*
  i2c slave top
  line sampler, bit engine, transaction FSM and register port
  joined into one slave with an open-drain sda pull output
*/
module i2c_slave_top (
  input  logic                                  sysclk,
  input  logic                                  reset_n,
  input  logic                                  scl,
  input  logic                                  sda,
  input  logic [i2c_slave_pkg::addr_w-1:0]      device_address,
  output logic                                  sda_pull,
  input  i2c_slave_pkg::port_bytes_t            port_data,
  output i2c_slave_pkg::reg_access_t            reg_access
);

  i2c_slave_pkg::bus_events_t        events;
  i2c_slave_pkg::bit_status_t        status;
  i2c_slave_pkg::slave_ctrl_t        ctrl;
  logic [i2c_slave_pkg::byte_w-1:0]  location;
  logic [i2c_slave_pkg::byte_w-1:0]  read_byte;
  logic                              wr_strobe;
  logic                              rd_strobe;

  ////////////////////////////////////////////////////////////////////////////
  // bus side
  ////////////////////////////////////////////////////////////////////////////
  i2c_line_sampler u_line_sampler (
    .sysclk    (sysclk),
    .reset_n   (reset_n),
    .scl       (scl),
    .sda       (sda),
    .events    (events)
  );

  i2c_bit_engine u_bit_engine (
    .sysclk    (sysclk),
    .reset_n   (reset_n),
    .events    (events),
    .ctrl      (ctrl),
    .read_byte (read_byte),
    .status    (status),
    .sda_pull  (sda_pull)
  );

  ////////////////////////////////////////////////////////////////////////////
  // transfer control and register side
  ////////////////////////////////////////////////////////////////////////////
  i2c_transaction_fsm u_transaction_fsm (
    .sysclk         (sysclk),
    .reset_n        (reset_n),
    .events         (events),
    .status         (status),
    .device_address (device_address),
    .ctrl           (ctrl),
    .location       (location),
    .wr_strobe      (wr_strobe),
    .rd_strobe      (rd_strobe)
  );

  // write data comes straight from the receive shifter
  i2c_register_port u_register_port (
    .sysclk     (sysclk),
    .reset_n    (reset_n),
    .location   (location),
    .wr_strobe  (wr_strobe),
    .rd_strobe  (rd_strobe),
    .wdata      (status.rx_byte),
    .port_data  (port_data),
    .reg_access (reg_access),
    .read_byte  (read_byte)
  );

endmodule

//--- test/i2c_bus_master.sv
/*
  i2c bus master model
  drives scl and an open-drain sda pull with ten-cycle phases,
  offers start, stop, byte write and byte read tasks
*/
module i2c_bus_master (
  input  logic sysclk,
  input  logic sda_line,
  output logic scl,
  output logic sda_low
);

  timeunit 1ns;
  timeprecision 100ps;

  // all line changes land on falling sysclk
  task automatic wait_cycles(input int n);
    repeat (n) @(negedge sysclk);
  endtask

  // idle bus, both lines high
  task automatic release_lines();
    scl     = 1'b1;
    sda_low = 1'b0;
  endtask

  // one bit slot
  // sda set halfway through scl low, sampled halfway through scl high
  task automatic bit_slot(input logic pull, output logic level);
    wait_cycles(5);
    sda_low = pull;
    wait_cycles(5);
    scl = 1'b1;
    wait_cycles(5);
    level = sda_line;
    wait_cycles(5);
    scl = 1'b0;
  endtask

  // also serves as repeated start from scl low
  task automatic start_condition();
    wait_cycles(5);
    sda_low = 1'b0;
    wait_cycles(5);
    scl = 1'b1;
    wait_cycles(10);
    sda_low = 1'b1;
    wait_cycles(10);
    scl = 1'b0;
  endtask

  task automatic stop_condition();
    wait_cycles(5);
    sda_low = 1'b1;
    wait_cycles(5);
    scl = 1'b1;
    wait_cycles(10);
    sda_low = 1'b0;
    wait_cycles(10);
  endtask

  // msb first, then the slave ack slot
  task automatic write_byte(input logic [7:0] data, output logic acked);
    logic level;
    for (int i = 7; i >= 0; i--)
      bit_slot(~data[i], level);
    bit_slot(1'b0, level);
    acked = ~level;
  endtask

  // ack set means pull sda low in the ninth slot
  task automatic read_byte(input logic ack, output logic [7:0] data);
    logic level;
    data = '0;
    for (int i = 0; i < 8; i++)
    begin
      bit_slot(1'b0, level);
      data = {data[6:0], level};
    end
    bit_slot(ack, level);
  endtask

endmodule

//--- test/tb_i2c_slave.sv
/*
  i2c slave testbench
  runs a table of write and read transfers through the bus master
  model, checks acks, logged register writes and read data
*/
module tb_i2c_slave;

  timeunit 1ns;
  timeprecision 100ps;

  localparam logic [6:0] dev_addr   = 7'h2A;
  localparam int         test_count = 7;
  localparam int         wait_limit = 400;

  // one row of the stimulus table
  typedef struct packed {
    logic [6:0] addr;
    logic       rd;
    logic [7:0] loc;
    logic [3:0] count;
    logic       ack;
  } test_entry_t;

  // register write as seen on reg_access
  typedef struct packed {
    logic [15:0] port_sel;
    logic [15:0] offset_sel;
    logic [7:0]  wdata;
  } wr_record_t;

  // addr, direction, location, byte count, expected ack
  test_entry_t test_table [test_count] = '{
    '{dev_addr, 1'b0, 8'h37, 4'd1, 1'b1},
    '{dev_addr, 1'b0, 8'h5C, 4'd3, 1'b1},
    '{dev_addr, 1'b1, 8'h4F, 4'd2, 1'b1},
    '{7'h15,    1'b0, 8'h10, 4'd1, 1'b0},
    '{dev_addr, 1'b0, 8'h82, 4'd1, 1'b1},
    '{dev_addr, 1'b1, 8'hA3, 4'd1, 1'b1},
    '{dev_addr, 1'b0, 8'hE9, 4'd1, 1'b1}
  };
  string test_names [test_count] = '{"write_single", "write_burst", "read_pair",
    "addr_mismatch", "write_after_miss", "read_nack_release", "write_after_read"};

  logic                       sysclk;
  logic                       reset_n;
  logic                       scl;
  logic                       sda;
  logic                       master_sda_low;
  logic                       sda_pull;
  logic [6:0]                 device_address;
  i2c_slave_pkg::port_bytes_t port_data;
  i2c_slave_pkg::reg_access_t reg_access;

  logic [15:0]                lfsr;
  wr_record_t                 wr_log [$];
  int                         rd_seen;
  int                         pull_seen;
  logic                       watch_release;
  string                      cur_name;
  int                         test_errors;
  int                         total_errors;
  int                         tests_failed;

  // wired-and bus, master or slave can pull low
  assign sda = ~(master_sda_low | sda_pull);

  i2c_slave_top i_dut (
    .sysclk         (sysclk),
    .reset_n        (reset_n),
    .scl            (scl),
    .sda            (sda),
    .device_address (device_address),
    .sda_pull       (sda_pull),
    .port_data      (port_data),
    .reg_access     (reg_access)
  );

  i2c_bus_master i_master (
    .sysclk   (sysclk),
    .sda_line (sda),
    .scl      (scl),
    .sda_low  (master_sda_low)
  );

  initial
  begin
    sysclk = 1'b0;
    forever #20 sysclk = ~sysclk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // monitor, sampled away from the active edge
  ////////////////////////////////////////////////////////////////////////////
  always @(negedge sysclk)
  begin
    if (reg_access.wr)
      wr_log.push_back({reg_access.port_sel, reg_access.offset_sel, reg_access.wdata});
    if (reg_access.rd)
      rd_seen++;
    // slave must stay off sda after a master nack
    if (watch_release && sda_pull)
      pull_seen++;
  end

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic random_byte(output logic [7:0] b);
    b = '0;
    for (int i = 0; i < 8; i++)
    begin
      lfsr = lfsr_next(lfsr);
      b    = {b[6:0], lfsr[0]};
    end
  endtask

  task automatic compare_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
    assert (actual === expected)
    else
    begin
      $display("FAIL %s %s expected %0h actual %0h", cur_name, what, expected, actual);
      test_errors++;
    end
  endtask

  task automatic await_writes(input int target);
    int waited;
    waited = 0;
    while (wr_log.size() < target && waited < wait_limit)
    begin
      @(negedge sysclk);
      waited++;
    end
    if (wr_log.size() < target)
    begin
      $display("timeout in %s, register write never showed up", cur_name);
      test_errors++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // transfers
  ////////////////////////////////////////////////////////////////////////////
  task automatic run_write(input test_entry_t t, input int log_base);
    logic       acked;
    logic [7:0] data [16];
    logic [7:0] loc_k;
    wr_record_t rec;
    int         n;
    i_master.start_condition();
    i_master.write_byte({t.addr, 1'b0}, acked);
    compare_value("address ack", 32'(t.ack), 32'(acked));
    if (acked)
    begin
      i_master.write_byte(t.loc, acked);
      compare_value("location ack", 32'd1, 32'(acked));
      for (int k = 0; k < int'(t.count); k++)
      begin
        random_byte(data[k]);
        i_master.write_byte(data[k], acked);
        compare_value("data ack", 32'd1, 32'(acked));
      end
    end
    i_master.stop_condition();
    n = t.ack ? int'(t.count) : 0;
    await_writes(log_base + n);
    // pointer steps by one after each byte
    for (int k = 0; k < n && log_base + k < wr_log.size(); k++)
    begin
      loc_k = t.loc + 8'(k);
      rec   = wr_log[log_base + k];
      compare_value("port_sel", 32'(16'(1) << loc_k[7:4]), 32'(rec.port_sel));
      compare_value("offset_sel", 32'(16'(1) << loc_k[3:0]), 32'(rec.offset_sel));
      compare_value("wdata", 32'(data[k]), 32'(rec.wdata));
    end
  endtask

  // set location, repeated start, read back, nack on the last byte
  task automatic run_read(input test_entry_t t);
    logic       acked;
    logic       ack_it;
    logic [7:0] got;
    logic [7:0] loc_k;
    int         pull_base;
    pull_base = pull_seen;
    i_master.start_condition();
    i_master.write_byte({t.addr, 1'b0}, acked);
    compare_value("address ack", 32'(t.ack), 32'(acked));
    if (acked)
    begin
      i_master.write_byte(t.loc, acked);
      compare_value("location ack", 32'd1, 32'(acked));
      i_master.start_condition();
      i_master.write_byte({t.addr, 1'b1}, acked);
      compare_value("read address ack", 32'd1, 32'(acked));
      for (int k = 0; k < int'(t.count); k++)
      begin
        loc_k  = t.loc + 8'(k);
        ack_it = k < int'(t.count) - 1;
        i_master.read_byte(ack_it, got);
        compare_value("read data", 32'(port_data[loc_k[7:4]]), 32'(got));
      end
      watch_release = 1'b1;
    end
    i_master.stop_condition();
    watch_release = 1'b0;
    compare_value("sda pull after nack", 32'd0, 32'(pull_seen - pull_base));
  endtask

  initial
  begin
    logic [7:0]  b;
    test_entry_t t;
    int          wr_base;
    int          rd_base;
    int          exp_wr;
    int          exp_rd;
    reset_n        = 1'b0;
    device_address = dev_addr;
    watch_release  = 1'b0;
    total_errors   = 0;
    tests_failed   = 0;
    lfsr           = 16'd15844;
    for (int p = 0; p < 16; p++)
    begin
      random_byte(b);
      port_data[4'(p)] = b;
    end
    i_master.release_lines();
    repeat (2) @(negedge sysclk);
    reset_n = 1'b1;
    repeat (2) @(negedge sysclk);

    for (int n = 0; n < test_count; n++)
    begin
      t           = test_table[n];
      cur_name    = test_names[n];
      test_errors = 0;
      wr_base     = wr_log.size();
      rd_base     = rd_seen;
      exp_wr      = (!t.rd && t.ack) ? int'(t.count) : 0;
      exp_rd      = (t.rd && t.ack) ? int'(t.count) : 0;
      if (t.rd)
        run_read(t);
      else
        run_write(t, wr_base);
      compare_value("write count", 32'(exp_wr), 32'(wr_log.size() - wr_base));
      compare_value("read count", 32'(exp_rd), 32'(rd_seen - rd_base));
      if (test_errors == 0)
        $display("test %s passed", cur_name);
      else
      begin
        $display("test %s had %0d errors", cur_name, test_errors);
        tests_failed++;
      end
      total_errors += test_errors;
    end

    $display("tests run %0d, tests with errors %0d, total errors %0d",
             test_count, tests_failed, total_errors);
    if (total_errors == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

endmodule

//--- vlog.f
hw/i2c_slave_pkg.sv
hw/i2c_line_sampler.sv
hw/i2c_bit_engine.sv
hw/i2c_transaction_fsm.sv
hw/i2c_register_port.sv
hw/i2c_slave_top.sv
test/i2c_bus_master.sv
test/tb_i2c_slave.sv

//--- run_sim.sh
#!/bin/sh
# build the i2c slave testbench with Verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_i2c_slave \
  -f vlog.f -o tb_i2c_slave > build.log 2>&1 || { cat build.log; echo "build error"; exit 1; }
# a crashed simulation counts as a failure
./obj_dir/tb_i2c_slave > sim.log 2>&1 || echo "Test failed" >> sim.log
cat sim.log
grep -q "Test failed" sim.log && exit 1
grep -q "Test completed successfully" sim.log || exit 1
exit 0
